// ==== src/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------

    localparam int dataWidth    = 16;
    localparam int instrWidth   = 16;
    localparam int immWidth     = 8;
    localparam int regCount     = 8;
    localparam int regAddrWidth = 3;

    // --------------------------------------------------
    // Instruction fields
    // --------------------------------------------------

    typedef enum logic [2:0] {
        opMov = 3'b110,
        opAlu = 3'b101
    } opcodeT;

    typedef enum logic [1:0] {
        aluAdd = 2'b00,
        aluCmp = 2'b01,
        aluAnd = 2'b10,
        aluMvn = 2'b11
    } aluOpT;

    typedef enum logic [1:0] {
        shNone         = 2'b00,
        shLeft         = 2'b01,
        shRightLogical = 2'b10,
        shRightArith   = 2'b11
    } shiftT;

    // The op field of a MOV picks the form of the move.
    localparam logic [1:0] movImmediate = 2'b10;
    localparam logic [1:0] movRegister  = 2'b00;

    // --------------------------------------------------
    // Control
    // --------------------------------------------------

    typedef enum logic [1:0] {
        selRn,
        selRd,
        selRm
    } regSelectT;

    typedef enum logic {
        srcImmediate,
        srcResult
    } writeSourceT;

    typedef enum logic [2:0] {
        stWait,
        stWriteImm,
        stGetA,
        stGetB,
        stCompute,
        stWriteRd,
        stWriteFlags
    } ctrlStateT;

    typedef struct packed {
        opcodeT                 opcode;
        logic [1:0]             op;
        shiftT                  shift;
        logic [dataWidth-1:0]   imm16;   // Already sign-extended.
    } decodedInstrT;

    typedef struct packed {
        regSelectT   regSel;
        writeSourceT writeSource;
        logic        regWrite;
        logic        loadA;
        logic        loadB;
        logic        loadC;
        logic        loadStatus;
        logic        zeroA;   // Used by MOV and MVN, which have no A operand.
    } datapathCtrlT;

    typedef struct packed {
        logic zero;
        logic negative;
        logic overflow;
    } statusT;

endpackage

`default_nettype wire

// ==== src/instructionDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instructionDecoder (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [cpuPkg::instrWidth-1:0]     instrIn,
    input  logic                              load,
    input  cpuPkg::regSelectT                 regSel,
    output cpuPkg::decodedInstrT              decoded,
    output logic [cpuPkg::regAddrWidth-1:0]   regAddr
);
    import cpuPkg::*;

    logic [instrWidth-1:0]   instr;
    logic [regAddrWidth-1:0] rn;
    logic [regAddrWidth-1:0] rd;
    logic [regAddrWidth-1:0] rm;

    // An all-zero word decodes as an invalid opcode, so a start before any load is ignored.
    always_ff @(posedge clk) begin
        if (reset) begin
            instr <= '0;
        end else if (load) begin
            instr <= instrIn;
        end
    end

    // --------------------------------------------------
    // Field split
    // --------------------------------------------------

    assign rn = instr[10:8];
    assign rd = instr[7:5];
    assign rm = instr[2:0];

    assign decoded.opcode = opcodeT'(instr[15:13]);
    assign decoded.op     = instr[12:11];
    assign decoded.shift  = shiftT'(instr[4:3]);
    assign decoded.imm16  = {{(dataWidth - immWidth){instr[immWidth-1]}}, instr[immWidth-1:0]};

    // The controller decides which register number the register file sees.
    always_comb begin
        case (regSel)
            selRn:   regAddr = rn;
            selRd:   regAddr = rd;
            selRm:   regAddr = rm;
            default: regAddr = rn;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/cpuController.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuController (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  cpuPkg::decodedInstrT  decoded,
    output cpuPkg::datapathCtrlT  ctrl,
    output logic                  waiting
);
    import cpuPkg::*;

    ctrlStateT state;
    ctrlStateT nextState;
    logic      isMov;
    logic      isAlu;
    aluOpT     aluOp;

    assign isMov = (decoded.opcode == opMov);
    assign isAlu = (decoded.opcode == opAlu);
    assign aluOp = aluOpT'(decoded.op);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stWait;
        end else begin
            state <= nextState;
        end
    end

    assign waiting = (state == stWait);

    // --------------------------------------------------
    // Next state
    // --------------------------------------------------

    always_comb begin
        nextState = state;
        case (state)
            stWait: begin
                if (start) begin
                    if (isMov && decoded.op == movImmediate) begin
                        nextState = stWriteImm;
                    end else if (isMov && decoded.op == movRegister) begin
                        nextState = stGetB;   // No A operand for a move.
                    end else if (isAlu && aluOp == aluMvn) begin
                        nextState = stGetB;
                    end else if (isAlu) begin
                        nextState = stGetA;
                    end
                    // Anything else leaves the core waiting.
                end
            end
            stWriteImm: nextState = stWait;
            stGetA:     nextState = stGetB;
            stGetB:     nextState = stCompute;
            stCompute: begin
                if (isAlu && aluOp == aluCmp) begin
                    nextState = stWriteFlags;
                end else begin
                    nextState = stWriteRd;
                end
            end
            stWriteRd:    nextState = stWait;
            stWriteFlags: nextState = stWait;
            default:      nextState = stWait;
        endcase
    end

    // --------------------------------------------------
    // Control bundle
    // --------------------------------------------------

    always_comb begin
        ctrl.regSel      = selRn;
        ctrl.writeSource = srcResult;
        ctrl.regWrite    = 1'b0;
        ctrl.loadA       = 1'b0;
        ctrl.loadB       = 1'b0;
        ctrl.loadC       = 1'b0;
        ctrl.loadStatus  = 1'b0;
        ctrl.zeroA       = 1'b0;
        case (state)
            stWriteImm: begin
                ctrl.regSel      = selRn;
                ctrl.writeSource = srcImmediate;
                ctrl.regWrite    = 1'b1;
            end
            stGetA: begin
                ctrl.regSel = selRn;
                ctrl.loadA  = 1'b1;
            end
            stGetB: begin
                ctrl.regSel = selRm;
                ctrl.loadB  = 1'b1;
            end
            stCompute: begin
                ctrl.loadC = 1'b1;
                ctrl.zeroA = isMov || (isAlu && aluOp == aluMvn);
            end
            stWriteRd: begin
                ctrl.regSel      = selRd;
                ctrl.writeSource = srcResult;
                ctrl.regWrite    = 1'b1;
            end
            stWriteFlags: ctrl.loadStatus = 1'b1;   // A and B still hold the CMP operands.
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/registerFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              writeEnable,
    input  logic [cpuPkg::regAddrWidth-1:0]   addr,
    input  logic [cpuPkg::dataWidth-1:0]      writeData,
    output logic [cpuPkg::dataWidth-1:0]      readData
);
    import cpuPkg::*;

    logic [dataWidth-1:0] regs [regCount];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable) begin
            regs[addr] <= writeData;
        end
    end

    // Single port, so the read follows whatever address the controller selects.
    assign readData = regs[addr];

endmodule

`default_nettype wire

// ==== src/executeUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module executeUnit (
    input  logic [cpuPkg::dataWidth-1:0]   operandA,
    input  logic [cpuPkg::dataWidth-1:0]   operandB,
    input  cpuPkg::shiftT                  shift,
    input  cpuPkg::aluOpT                  aluOp,
    output logic [cpuPkg::dataWidth-1:0]   result,
    output cpuPkg::statusT                 flags
);
    import cpuPkg::*;

    logic [dataWidth-1:0] shiftedB;
    logic [dataWidth-1:0] sum;
    logic [dataWidth-1:0] difference;
    logic                 addOverflow;
    logic                 subOverflow;

    // --------------------------------------------------
    // Shifter
    // --------------------------------------------------

    always_comb begin
        case (shift)
            shNone:         shiftedB = operandB;
            shLeft:         shiftedB = {operandB[dataWidth-2:0], 1'b0};
            shRightLogical: shiftedB = {1'b0, operandB[dataWidth-1:1]};
            shRightArith:   shiftedB = {operandB[dataWidth-1], operandB[dataWidth-1:1]};
            default:        shiftedB = operandB;
        endcase
    end

    // --------------------------------------------------
    // ALU
    // --------------------------------------------------

    assign sum        = operandA + shiftedB;
    assign difference = operandA - shiftedB;

    // Signed overflow shows up as a sign flip that the operand signs do not allow.
    assign addOverflow = (operandA[dataWidth-1] == shiftedB[dataWidth-1])
                      && (sum[dataWidth-1] != operandA[dataWidth-1]);
    assign subOverflow = (operandA[dataWidth-1] != shiftedB[dataWidth-1])
                      && (difference[dataWidth-1] != operandA[dataWidth-1]);

    always_comb begin
        case (aluOp)
            aluAdd:  result = sum;
            aluCmp:  result = difference;
            aluAnd:  result = operandA & shiftedB;
            aluMvn:  result = ~shiftedB;
            default: result = sum;
        endcase
    end

    always_comb begin
        flags.zero     = (result == '0);
        flags.negative = result[dataWidth-1];
        case (aluOp)
            aluAdd:  flags.overflow = addOverflow;
            aluCmp:  flags.overflow = subOverflow;
            default: flags.overflow = 1'b0;   // Logic operations never overflow.
        endcase
    end

endmodule

`default_nettype wire

// ==== src/datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module datapath (
    input  logic                              clk,
    input  logic                              reset,
    input  cpuPkg::datapathCtrlT              ctrl,
    input  cpuPkg::decodedInstrT              decoded,
    input  logic [cpuPkg::regAddrWidth-1:0]   regAddr,
    output logic [cpuPkg::dataWidth-1:0]      result,
    output cpuPkg::statusT                    status
);
    import cpuPkg::*;

    logic [dataWidth-1:0] regA;
    logic [dataWidth-1:0] regB;
    logic [dataWidth-1:0] regC;
    statusT               statusReg;
    logic [dataWidth-1:0] readData;
    logic [dataWidth-1:0] writeData;
    logic [dataWidth-1:0] operandA;
    logic [dataWidth-1:0] aluResult;
    statusT               aluFlags;
    aluOpT                aluOp;

    // --------------------------------------------------
    // Register file and write-back
    // --------------------------------------------------

    assign writeData = (ctrl.writeSource == srcImmediate) ? decoded.imm16 : regC;

    registerFile registerFile_i (
        .clk         (clk),
        .reset       (reset),
        .writeEnable (ctrl.regWrite),
        .addr        (regAddr),
        .writeData   (writeData),
        .readData    (readData)
    );

    // --------------------------------------------------
    // Operand and result registers
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            regA      <= '0;
            regB      <= '0;
            regC      <= '0;
            statusReg <= '0;
        end else begin
            if (ctrl.loadA) regA <= readData;
            if (ctrl.loadB) regB <= readData;
            if (ctrl.loadC) regC <= aluResult;
            if (ctrl.loadStatus) statusReg <= aluFlags;
        end
    end

    // A move is an add with A forced to zero, which leaves just the shifted B.
    assign aluOp    = (decoded.opcode == opAlu) ? aluOpT'(decoded.op) : aluAdd;
    assign operandA = ctrl.zeroA ? '0 : regA;

    executeUnit executeUnit_i (
        .operandA (operandA),
        .operandB (regB),
        .shift    (decoded.shift),
        .aluOp    (aluOp),
        .result   (aluResult),
        .flags    (aluFlags)
    );

    assign result = regC;
    assign status = statusReg;

endmodule

`default_nettype wire

// ==== src/simpleCpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module simpleCpu (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [cpuPkg::instrWidth-1:0]     instrIn,
    input  logic                              load,
    input  logic                              start,
    output logic                              waiting,
    output logic [cpuPkg::dataWidth-1:0]      result,
    output cpuPkg::statusT                    status
);
    import cpuPkg::*;

    decodedInstrT            decoded;
    datapathCtrlT            ctrl;
    logic [regAddrWidth-1:0] regAddr;

    instructionDecoder instructionDecoder_i (
        .clk     (clk),
        .reset   (reset),
        .instrIn (instrIn),
        .load    (load),
        .regSel  (ctrl.regSel),
        .decoded (decoded),
        .regAddr (regAddr)
    );

    // Steps the datapath through one instruction at a time.
    cpuController cpuController_i (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .decoded (decoded),
        .ctrl    (ctrl),
        .waiting (waiting)
    );

    datapath datapath_i (
        .clk     (clk),
        .reset   (reset),
        .ctrl    (ctrl),
        .decoded (decoded),
        .regAddr (regAddr),
        .result  (result),
        .status  (status)
    );

endmodule

`default_nettype wire

// ==== bench/simpleCpuTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module simpleCpuTb;
    import cpuPkg::*;

    typedef struct packed {
        logic [dataWidth-1:0] instr;
        logic [dataWidth-1:0] expResult;
        statusT               expStatus;
        logic [3:0]           expCycles;
        logic                 busyStart;   // Start stays high into the busy cycles.
    } entryT;

    logic                 clk;
    logic                 reset;
    logic [dataWidth-1:0] instrIn;
    logic                 load;
    logic                 start;
    logic                 waiting;
    logic [dataWidth-1:0] result;
    statusT               status;

    entryT                entries[$];
    logic [dataWidth-1:0] modelRegs [regCount];
    logic [dataWidth-1:0] modelResult;
    statusT               modelStatus;
    int                   dataErrors;
    int                   statusErrors;
    int                   cycleErrors;
    int                   waitErrors;
    int                   cycleCount;
    int                   cycleLimit;

    simpleCpu simpleCpu_i (
        .clk     (clk),
        .reset   (reset),
        .instrIn (instrIn),
        .load    (load),
        .start   (start),
        .waiting (waiting),
        .result  (result),
        .status  (status)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout after %0d cycles, the DUT never returned to waiting.", cycleCount);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------

    task automatic compareData(input string name, input logic [dataWidth-1:0] expected,
                               input logic [dataWidth-1:0] actual);
        if (actual !== expected) begin
            $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
            dataErrors++;
        end
    endtask

    task automatic compareStatus(input string name, input statusT expected, input statusT actual);
        if (actual !== expected) begin
            $display("Fail at %0t: %s expected zero/negative/overflow %b, got %b",
                     $time, name, expected, actual);
            statusErrors++;
        end
    endtask

    task automatic compareCycles(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("Fail at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            cycleErrors++;
        end
    endtask

    task automatic compareBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Fail at %0t: %s expected %b, got %b", $time, name, expected, actual);
            waitErrors++;
        end
    endtask

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------

    function automatic logic [dataWidth-1:0] shiftValue(input logic [dataWidth-1:0] value,
                                                        input shiftT code);
        case (code)
            shLeft:         return value << 1;
            shRightLogical: return value >> 1;
            shRightArith:   return {value[dataWidth-1], value[dataWidth-1:1]};
            default:        return value;
        endcase
    endfunction

    function automatic logic [dataWidth-1:0] instrWord(input opcodeT opcode, input logic [1:0] op,
            input logic [2:0] rn, input logic [2:0] rd, input shiftT sh, input logic [2:0] rm);
        return {opcode, op, rn, rd, sh, rm};
    endfunction

    function automatic logic [dataWidth-1:0] movImmWord(input logic [2:0] rn,
                                                        input logic [7:0] imm);
        return {opMov, 2'b10, rn, imm};
    endfunction

    task automatic applyModel(input logic [dataWidth-1:0] instr, output int cycles);
        logic [dataWidth-1:0]      a;
        logic [dataWidth-1:0]      b;
        logic signed [dataWidth:0] wide;
        a = modelRegs[instr[10:8]];
        b = shiftValue(modelRegs[instr[2:0]], shiftT'(instr[4:3]));
        cycles = 1;   // Anything unknown is ignored on the accepting edge.
        if (instr[15:13] == opMov && instr[12:11] == 2'b10) begin
            modelRegs[instr[10:8]] = {{8{instr[7]}}, instr[7:0]};
            cycles = 2;
        end else if (instr[15:13] == opMov && instr[12:11] == 2'b00) begin
            modelResult = b;
            modelRegs[instr[7:5]] = b;
            cycles = 4;
        end else if (instr[15:13] == opAlu) begin
            case (instr[12:11])
                2'b00:   modelResult = a + b;
                2'b01:   modelResult = a - b;
                2'b10:   modelResult = a & b;
                default: modelResult = ~b;
            endcase
            cycles = (instr[12:11] == 2'b11) ? 4 : 5;
            if (instr[12:11] == 2'b01) begin
                // A signed result outside 16 bits shows as bits 16 and 15 differing.
                wide = $signed({a[dataWidth-1], a}) - $signed({b[dataWidth-1], b});
                modelStatus.zero     = (modelResult == '0);
                modelStatus.negative = modelResult[dataWidth-1];
                modelStatus.overflow = (wide[dataWidth] != wide[dataWidth-1]);
            end else begin
                modelRegs[instr[7:5]] = modelResult;
            end
        end
    endtask

    task automatic addEntry(input logic [dataWidth-1:0] instr, input logic busyStart);
        entryT entry;
        int    cycles;
        applyModel(instr, cycles);
        entry.instr     = instr;
        entry.expResult = modelResult;
        entry.expStatus = modelStatus;
        entry.expCycles = 4'(cycles);
        entry.busyStart = busyStart;
        entries.push_back(entry);
    endtask

    // --------------------------------------------------
    // Stimulus table
    // --------------------------------------------------

    task automatic buildTable();
        logic [1:0] op;
        addEntry(movImmWord(3'd1, 8'h80), 1'b0);   // Negative immediate.
        addEntry(instrWord(opMov, 2'b00, 3'd0, 3'd2, shNone, 3'd1), 1'b0);
        addEntry(movImmWord(3'd3, 8'h7F), 1'b1);
        addEntry(instrWord(opMov, 2'b00, 3'd0, 3'd4, shNone, 3'd3), 1'b0);
        for (int i = 0; i < 4; i++) begin
            addEntry(movImmWord(3'd5, 8'($urandom())), 1'b0);
            addEntry(instrWord(opMov, 2'b00, 3'd0, 3'd6, shNone, 3'd5), 1'b0);
        end
        // R1 holds a negative value, so the two right shifts differ.
        for (int s = 0; s < 4; s++) begin
            addEntry(instrWord(opMov, 2'b00, 3'd0, 3'd6, shiftT'(s[1:0]), 3'd1), 1'b0);
            addEntry(instrWord(opAlu, 2'b11, 3'd0, 3'd7, shiftT'(s[1:0]), 3'd1), 1'b0);
        end
        addEntry(movImmWord(3'd1, 8'd5), 1'b0);
        addEntry(movImmWord(3'd2, 8'd5), 1'b0);
        addEntry(instrWord(opAlu, 2'b01, 3'd1, 3'd0, shNone, 3'd2), 1'b0);
        addEntry(movImmWord(3'd3, 8'd3), 1'b0);
        addEntry(movImmWord(3'd4, 8'd7), 1'b0);
        addEntry(instrWord(opAlu, 2'b01, 3'd3, 3'd0, shNone, 3'd4), 1'b1);
        addEntry(movImmWord(3'd5, 8'hFF), 1'b0);
        addEntry(instrWord(opMov, 2'b00, 3'd0, 3'd6, shRightLogical, 3'd5), 1'b0);
        addEntry(instrWord(opAlu, 2'b11, 3'd0, 3'd7, shRightLogical, 3'd5), 1'b0);
        addEntry(instrWord(opAlu, 2'b01, 3'd7, 3'd0, shNone, 3'd6), 1'b0);
        addEntry(instrWord(opAlu, 2'b01, 3'd6, 3'd0, shNone, 3'd5), 1'b0);
        for (int i = 0; i < regCount; i++) begin
            addEntry(movImmWord(3'(i), 8'($urandom())), 1'b0);
        end
        for (int i = 0; i < 12; i++) begin
            op = (i % 2 == 0) ? 2'b00 : 2'b10;   // ADD and AND in turn.
            addEntry(instrWord(opAlu, op, 3'($urandom()), 3'($urandom()),
                               shiftT'(2'($urandom())), 3'($urandom())), i == 5);
        end
        // --------------------------------------------------
        // Codes that the core must ignore
        addEntry(16'h0000, 1'b0);
        addEntry(16'hE000, 1'b0);
        addEntry(16'h2345, 1'b0);
        addEntry(instrWord(opMov, 2'b01, 3'd1, 3'd2, shNone, 3'd3), 1'b0);
        addEntry(instrWord(opMov, 2'b11, 3'd1, 3'd2, shNone, 3'd3), 1'b0);
    endtask

    task automatic runEntry(input entryT entry);
        int edges;
        @(posedge clk);
        #5;
        instrIn = entry.instr;
        load    = 1'b1;
        @(posedge clk);
        #5;
        load  = 1'b0;
        start = 1'b1;
        @(posedge clk);   // This edge accepts the start.
        edges = 1;
        #5;
        start = entry.busyStart;
        while (waiting !== 1'b1) begin
            @(posedge clk);
            edges++;
            #5;
            start = 1'b0;
        end
        start = 1'b0;
        compareCycles("latency", int'(entry.expCycles), edges);
        compareData("result", entry.expResult, result);
        compareStatus("status", entry.expStatus, status);
        if (entry.busyStart) begin
            @(posedge clk);
            #5;
            compareBit("waiting", 1'b1, waiting);   // The extra start must not have queued a rerun.
        end
    endtask

    initial begin
        reset        = 1'b1;
        instrIn      = '0;
        load         = 1'b0;
        start        = 1'b0;
        dataErrors   = 0;
        statusErrors = 0;
        cycleErrors  = 0;
        waitErrors   = 0;
        cycleCount   = 0;
        cycleLimit   = 1000;
        void'($urandom(32'h76675ff7));
        for (int i = 0; i < regCount; i++) begin
            modelRegs[i] = '0;
        end
        modelResult = '0;
        modelStatus = '0;
        buildTable();
        cycleLimit = entries.size() * 8 + 20;

        repeat (3) @(posedge clk);
        #5;
        reset = 1'b0;
        compareBit("waiting", 1'b1, waiting);
        compareData("result", '0, result);
        compareStatus("status", '0, status);

        foreach (entries[i]) begin
            runEntry(entries[i]);
        end

        $display("Errors: data %0d, status %0d, latency %0d, waiting %0d", dataErrors,
                 statusErrors, cycleErrors, waitErrors);
        if (dataErrors + statusErrors + cycleErrors + waitErrors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
src/cpuPkg.sv
src/instructionDecoder.sv
src/cpuController.sv
src/registerFile.sv
src/executeUnit.sv
src/datapath.sv
src/simpleCpu.sv
bench/simpleCpuTb.sv

// ==== Makefile ====
# Verilator build and run of the simpleCpu testbench.

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 -f filelist.f --top-module simpleCpuTb -o simpleCpuTb

run: build
	./obj_dir/simpleCpuTb | tee sim.log
	grep -qF "*** TEST PASSED ***" sim.log

lint:
	verilator --lint-only --timing -Wall -f filelist.f --top-module simpleCpu

clean:
	rm -rf obj_dir sim.log
